// File: hw/div_types_pkg.sv
`default_nettype none

package div_types_pkg;

  localparam int DIVIDEND_W = 16;
  localparam int DIVISOR_W  = 8; // Quotient and remainder share this width.
  localparam int TAG_W      = 4;

  // Request as it arrives from upstream.
  typedef struct packed {
    logic [DIVIDEND_W-1:0] dividend;
    logic [DIVISOR_W-1:0]  divisor;
    logic [TAG_W-1:0]      tag;
  } div_req_t;

  // Result returned downstream.
  typedef struct packed {
    logic [DIVISOR_W-1:0] quotient;
    logic [DIVISOR_W-1:0] remainder;
    logic [TAG_W-1:0]     tag;
    logic                 div_by_zero;
    logic                 approx;    // Answered by the approximate array.
  } div_rsp_t;

endpackage

`default_nettype wire

// File: hw/div_cfg_pkg.sv
`default_nettype none

package div_cfg_pkg;

  localparam int CFG_DATA_W = 8;

  // Register map of the configuration port.
  typedef enum logic [1:0] {
    CFG_MODE      = 2'd0,
    CFG_DBZ_COUNT = 2'd1 // Any write clears the count.
  } cfg_addr_e;

  typedef enum logic {
    MODE_EXACT  = 1'b0,
    MODE_APPROX = 1'b1
  } div_mode_e;

  localparam logic [CFG_DATA_W-1:0] DBZ_COUNT_MAX = '1; // Counter saturates here.

endpackage

`default_nettype wire

// File: hw/divider_array.sv
`default_nettype none

module divider_array import div_types_pkg::*; #(
  parameter int APPROX_ROWS = 6
) (
  input  wire logic [DIVIDEND_W-1:0] dividend,
  input  wire logic [DIVISOR_W-1:0]  divisor,
  output logic      [DIVISOR_W-1:0]  quotient,
  output logic      [DIVISOR_W-1:0]  remainder
);

  // rem_row[i] is the partial remainder left by row i, brw_row[i] its borrow chain.
  wire [DIVISOR_W-1:0] rem_row [0:DIVISOR_W-1];
  wire [DIVISOR_W-1:0] brw_row [0:DIVISOR_W-1];
  wire [DIVISOR_W-1:0] q_bits;

  for (genvar i = 0; i < DIVISOR_W; i++) begin : g_row
    wire top_bit; // Minuend bit above the subtraction window.

    if (i == DIVISOR_W - 1) begin : g_top
      assign top_bit = dividend[DIVIDEND_W-1];
    end else begin : g_mid
      assign top_bit = rem_row[i+1][DIVISOR_W-1];
    end

    // Subtraction fits if nothing is left to borrow or a higher bit covers it.
    assign q_bits[i] = top_bit | ~brw_row[i][DIVISOR_W-1];

    for (genvar j = 0; j < DIVISOR_W; j++) begin : g_cell
      wire x;
      wire bin;
      wire diff;

      if (j == 0) begin : g_lsb
        assign x   = dividend[i]; // Next dividend bit brought down.
        assign bin = 1'b0;
      end else if (i == DIVISOR_W - 1) begin : g_first
        assign x   = dividend[DIVISOR_W-1+j];
        assign bin = brw_row[i][j-1];
      end else begin : g_inner
        assign x   = rem_row[i+1][j-1];
        assign bin = brw_row[i][j-1];
      end

      if (i < APPROX_ROWS) begin : g_apx
        // Difference tied high; borrow only ignores the y=0, bin=1 case.
        assign diff          = 1'b1;
        assign brw_row[i][j] = x & ~(~divisor[j] & bin);
      end else begin : g_exact
        assign diff          = x ^ divisor[j] ^ bin;
        assign brw_row[i][j] = (~x & divisor[j]) | (~(x ^ divisor[j]) & bin);
      end

      assign rem_row[i][j] = q_bits[i] ? diff : x; // Restore on a zero bit.
    end
  end

  assign quotient  = q_bits;
  assign remainder = rem_row[0];

endmodule

`default_nettype wire

// File: hw/div_req_fifo.sv
`default_nettype none

module div_req_fifo import div_types_pkg::*; #(
  parameter int FIFO_DEPTH = 4
) (
  input  wire logic     clk,
  input  wire logic     reset,
  input  wire logic     req_valid,
  input  wire div_req_t req,
  input  wire logic     pop,
  output div_req_t      head,
  output logic          not_empty,
  output logic          req_credit
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

  div_req_t             mem [FIFO_DEPTH];
  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W-1:0]     rd_ptr;
  logic [PTR_W:0]       count;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (req_valid) mem[wr_ptr] <= req;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      req_credit <= 1'b0;
    end else begin
      if (req_valid) wr_ptr <= next_ptr(wr_ptr);
      if (pop) rd_ptr <= next_ptr(rd_ptr);
      count      <= count + (PTR_W+1)'(req_valid) - (PTR_W+1)'(pop);
      req_credit <= pop; // One credit back per released entry.
    end
  end

  assign head      = mem[rd_ptr];
  assign not_empty = (count != '0);

  // Upstream only writes against a credit, so a full buffer never sees a write.
  a_no_write_when_full : assert property (
    @(posedge clk) disable iff (reset)
    req_valid |-> (count < (PTR_W+1)'(FIFO_DEPTH))
  );

endmodule

`default_nettype wire

// File: hw/div_mode_regs.sv
`default_nettype none

module div_mode_regs import div_cfg_pkg::*; (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire logic                  cfg_we,
  input  wire cfg_addr_e             cfg_addr,
  input  wire logic [CFG_DATA_W-1:0] cfg_wdata,
  output logic      [CFG_DATA_W-1:0] cfg_rdata,
  input  wire logic                  dbz_event,
  output div_mode_e                  mode
);

  logic [CFG_DATA_W-1:0] dbz_count;

  always_ff @(posedge clk) begin
    if (reset) begin
      mode      <= MODE_EXACT;
      dbz_count <= '0;
    end else begin
      if (cfg_we && cfg_addr == CFG_MODE) mode <= div_mode_e'(cfg_wdata[0]);
      // A clear by software wins over a coincident event.
      if (cfg_we && cfg_addr == CFG_DBZ_COUNT) begin
        dbz_count <= '0;
      end else if (dbz_event && dbz_count != DBZ_COUNT_MAX) begin
        dbz_count <= dbz_count + 1'b1;
      end
    end
  end

  always_comb begin
    case (cfg_addr)
      CFG_MODE:      cfg_rdata = {{(CFG_DATA_W-1){1'b0}}, mode};
      CFG_DBZ_COUNT: cfg_rdata = dbz_count;
      default:       cfg_rdata = '0; // Unmapped addresses read zero.
    endcase
  end

endmodule

`default_nettype wire

// File: hw/div_issue_ctrl.sv
`default_nettype none

module div_issue_ctrl import div_types_pkg::*; import div_cfg_pkg::*; #(
  parameter int APPROX_ROWS = 6,
  parameter int RSP_CREDITS = 2
) (
  input  wire logic      clk,
  input  wire logic      reset,
  input  wire div_req_t  head,
  input  wire logic      not_empty,
  input  wire div_mode_e mode,
  output logic           pop,
  input  wire logic      rsp_credit,
  output logic           rsp_valid,
  output div_rsp_t       rsp,
  output logic           dbz_event
);

  localparam int CRED_W = $clog2(RSP_CREDITS + 1);

  logic [CRED_W-1:0]    credits;
  logic                 s1_valid;
  div_req_t             s1_req;
  div_mode_e            s1_mode;
  logic                 s1_dbz;
  logic [DIVISOR_W-1:0] exact_q;
  logic [DIVISOR_W-1:0] exact_r;
  logic [DIVISOR_W-1:0] approx_q;
  logic [DIVISOR_W-1:0] approx_r;
  div_rsp_t             rsp_next;

  // Issue reserves a result slot downstream, so the pipeline never stalls.
  assign pop = not_empty && (credits != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      credits <= CRED_W'(RSP_CREDITS);
    end else begin
      case ({pop, rsp_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // Stage one: operands and the mode as seen at issue.
  always_ff @(posedge clk) begin
    if (reset) s1_valid <= 1'b0;
    else       s1_valid <= pop;
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      s1_req  <= head;
      s1_mode <= mode;
    end
  end

  divider_array #(.APPROX_ROWS(0)) u_exact_array (
    .dividend  (s1_req.dividend),
    .divisor   (s1_req.divisor),
    .quotient  (exact_q),
    .remainder (exact_r)
  );

  divider_array #(.APPROX_ROWS(APPROX_ROWS)) u_approx_array (
    .dividend  (s1_req.dividend),
    .divisor   (s1_req.divisor),
    .quotient  (approx_q),
    .remainder (approx_r)
  );

  assign s1_dbz    = (s1_req.divisor == '0);
  assign dbz_event = s1_valid && s1_dbz;

  always_comb begin
    rsp_next.tag         = s1_req.tag;
    rsp_next.div_by_zero = s1_dbz;
    rsp_next.approx      = (s1_mode == MODE_APPROX);
    if (s1_dbz) begin
      rsp_next.quotient  = '1;
      rsp_next.remainder = s1_req.dividend[DIVISOR_W-1:0];
    end else if (s1_mode == MODE_APPROX) begin
      rsp_next.quotient  = approx_q;
      rsp_next.remainder = approx_r;
    end else begin
      rsp_next.quotient  = exact_q;
      rsp_next.remainder = exact_r;
    end
  end

  // Stage two: registered result.
  always_ff @(posedge clk) begin
    if (reset) rsp_valid <= 1'b0;
    else       rsp_valid <= s1_valid;
  end

  always_ff @(posedge clk) begin
    if (s1_valid) rsp <= rsp_next;
  end

  // Consumer never hands back more credits than it was given.
  a_credit_bound : assert property (
    @(posedge clk) disable iff (reset)
    credits <= CRED_W'(RSP_CREDITS)
  );

endmodule

`default_nettype wire

// File: hw/approx_div_unit.sv
`default_nettype none

module approx_div_unit import div_types_pkg::*; import div_cfg_pkg::*; #(
  parameter int FIFO_DEPTH  = 4,
  parameter int APPROX_ROWS = 6,
  parameter int RSP_CREDITS = 2
) (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire logic                  req_valid,
  input  wire div_req_t              req,
  output logic                       req_credit,
  output logic                       rsp_valid,
  output div_rsp_t                   rsp,
  input  wire logic                  rsp_credit,
  input  wire logic                  cfg_we,
  input  wire cfg_addr_e             cfg_addr,
  input  wire logic [CFG_DATA_W-1:0] cfg_wdata,
  output logic      [CFG_DATA_W-1:0] cfg_rdata
);

  div_req_t  head;
  logic      not_empty;
  logic      pop;
  div_mode_e mode;
  logic      dbz_event;

  div_req_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_req_fifo (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (req_valid),
    .req        (req),
    .pop        (pop),
    .head       (head),
    .not_empty  (not_empty),
    .req_credit (req_credit)
  );

  div_issue_ctrl #(
    .APPROX_ROWS (APPROX_ROWS),
    .RSP_CREDITS (RSP_CREDITS)
  ) u_issue_ctrl (
    .clk        (clk),
    .reset      (reset),
    .head       (head),
    .not_empty  (not_empty),
    .mode       (mode),
    .pop        (pop),
    .rsp_credit (rsp_credit),
    .rsp_valid  (rsp_valid),
    .rsp        (rsp),
    .dbz_event  (dbz_event)
  );

  div_mode_regs u_mode_regs (
    .clk       (clk),
    .reset     (reset),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .dbz_event (dbz_event),
    .mode      (mode)
  );

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD = 20
) (
  output logic clk
);

  initial clk = 1'b0;

  always #(PERIOD / 2) clk = ~clk; // Free running.

endmodule

`default_nettype wire

// File: tb/approx_div_tb.sv
`default_nettype none

module approx_div_tb
  import div_types_pkg::*;
  import div_cfg_pkg::*;
();

  localparam int FIFO_DEPTH  = 4;
  localparam int APPROX_ROWS = 6;
  localparam int RSP_CREDITS = 2;
  localparam int N_EXACT     = 100;
  localparam int N_APPROX    = 40;
  localparam int N_DBZ       = 3;
  localparam int N_BP        = FIFO_DEPTH + RSP_CREDITS;
  localparam int TOTAL_REQS  = 1 + N_EXACT + N_APPROX + N_DBZ + N_BP;
  localparam int WATCHDOG_CYCLES = TOTAL_REQS * 20 + 2000;
  localparam int WAIT_LIMIT  = 1000; // Cycles allowed for any single wait.

  logic       clk;
  logic       reset;
  logic       req_valid;
  div_req_t   req;
  logic       req_credit;
  logic       rsp_valid;
  div_rsp_t   rsp;
  logic       rsp_credit;
  logic       cfg_we;
  cfg_addr_e  cfg_addr;
  logic [7:0] cfg_wdata;
  logic [7:0] cfg_rdata;

  div_rsp_t    exp_q[$];
  div_rsp_t    got_q[$];
  int          sent_count   = 0;
  int          credit_count = 0; // Upstream credits returned by the unit.
  int          owed         = 0; // Downstream credits still to hand back.
  int          tag_count    = 0;
  int          value_errors = 0;
  int          other_errors = 0;
  logic        hold_rsp     = 1'b0;
  logic        give_credit;
  logic [31:0] rng          = 32'he119_5c09;

  tb_clock_gen #(.PERIOD(20)) u_clk (.clk(clk));

  approx_div_unit #(
    .FIFO_DEPTH  (FIFO_DEPTH),
    .APPROX_ROWS (APPROX_ROWS),
    .RSP_CREDITS (RSP_CREDITS)
  ) uut (
    .clk, .reset, .req_valid, .req, .req_credit, .rsp_valid, .rsp, .rsp_credit,
    .cfg_we, .cfg_addr, .cfg_wdata, .cfg_rdata
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // Cell grid model, one quotient bit per row from the top down.
  function automatic logic [15:0] approx_grid(input logic [15:0] dividend,
                                              input logic [7:0] divisor);
    logic [7:0] rem;
    logic [7:0] x;
    logic [7:0] d;
    logic [7:0] q;
    logic       top;
    logic       b;
    logic       b_next;
    rem = dividend[15:8];
    for (int i = 7; i >= 0; i--) begin
      top = rem[7];
      x   = {rem[6:0], dividend[i]};
      b   = 1'b0;
      for (int j = 0; j < 8; j++) begin
        if (i < APPROX_ROWS) begin
          d[j]   = 1'b1;
          b_next = x[j] && !(!divisor[j] && b);
        end else begin
          d[j]   = x[j] ^ divisor[j] ^ b;
          b_next = (!x[j] && divisor[j]) || (!x[j] && b) || (divisor[j] && b);
        end
        b = b_next;
      end
      q[i] = top | ~b;
      rem  = q[i] ? d : x;
    end
    return {q, rem};
  endfunction

  function automatic div_rsp_t expected_rsp(input logic [15:0] dividend,
                                            input logic [7:0] divisor,
                                            input logic [3:0] tag,
                                            input logic approx_mode);
    div_rsp_t    r;
    logic [15:0] grid;
    r.tag         = tag;
    r.approx      = approx_mode;
    r.div_by_zero = (divisor == 8'd0);
    if (divisor == 8'd0) begin
      r.quotient  = 8'hff;
      r.remainder = dividend[7:0];
    end else if (approx_mode) begin
      grid        = approx_grid(dividend, divisor);
      r.quotient  = grid[15:8];
      r.remainder = grid[7:0];
    end else begin
      r.quotient  = 8'(dividend / divisor);
      r.remainder = 8'(dividend % divisor);
    end
    return r;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got === exp) else begin
      value_errors++;
      $display("Fail at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic write_cfg(input cfg_addr_e addr, input logic [7:0] data);
    cfg_addr  = addr;
    cfg_wdata = data;
    cfg_we    = 1'b1;
    next_cycle();
    cfg_we    = 1'b0;
  endtask

  task automatic read_cfg(input cfg_addr_e addr, output logic [7:0] data);
    cfg_addr = addr;
    #1;
    data = cfg_rdata;
  endtask

  task automatic send_req(input logic [15:0] dividend, input logic [7:0] divisor,
                          input logic approx_mode);
    div_req_t r;
    while (sent_count - credit_count >= FIFO_DEPTH) next_cycle(); // No upstream credit.
    r.dividend = dividend;
    r.divisor  = divisor;
    r.tag      = tag_count[3:0];
    exp_q.push_back(expected_rsp(dividend, divisor, r.tag, approx_mode));
    tag_count++;
    sent_count++;
    req       = r;
    req_valid = 1'b1;
    next_cycle();
    req_valid = 1'b0;
  endtask

  // Upper dividend byte stays below the divisor so the quotient fits.
  task automatic send_random(input logic approx_mode);
    logic [7:0] dvs;
    logic [7:0] hi;
    rng = xorshift32(rng);
    dvs = (rng[7:0] == 8'd0) ? 8'd1 : rng[7:0];
    hi  = rng[15:8] % dvs;
    send_req({hi, rng[23:16]}, dvs, approx_mode);
  endtask

  task automatic collect_and_check();
    int       n;
    int       waited;
    div_rsp_t got;
    div_rsp_t exp;
    n      = exp_q.size();
    waited = 0;
    while (got_q.size() < n && waited < WAIT_LIMIT) begin
      next_cycle();
      waited++;
    end
    if (got_q.size() < n) begin
      other_errors++;
      $display("Timed out waiting for results, %0d of %0d arrived", got_q.size(), n);
    end
    while (got_q.size() > 0 && exp_q.size() > 0) begin
      got = got_q.pop_front();
      exp = exp_q.pop_front();
      check_eq(got.tag, exp.tag, "tag");
      check_eq(got.quotient, exp.quotient, $sformatf("quotient of tag %0d", exp.tag));
      check_eq(got.remainder, exp.remainder, $sformatf("remainder of tag %0d", exp.tag));
      check_eq(got.div_by_zero, exp.div_by_zero, "div_by_zero flag");
      check_eq(got.approx, exp.approx, "approx flag");
    end
    if (got_q.size() > 0) begin
      other_errors++;
      $display("Unit returned %0d results that were never requested", got_q.size());
    end
    exp_q.delete();
    got_q.delete();
  endtask

  task automatic test_reset_state();
    logic [7:0] data;
    repeat (4) begin
      check_eq(rsp_valid, 1'b0, "rsp_valid after reset");
      check_eq(req_credit, 1'b0, "req_credit after reset");
      next_cycle();
    end
    read_cfg(CFG_MODE, data);
    check_eq(data, 8'd0, "mode after reset");
    read_cfg(CFG_DBZ_COUNT, data);
    check_eq(data, 8'd0, "divide-by-zero count after reset");
  endtask

  task automatic test_exact();
    send_random(1'b0);
    next_cycle();
    check_eq(rsp_valid, 1'b0, "rsp_valid two cycles after a lone request");
    next_cycle();
    check_eq(rsp_valid, 1'b1, "rsp_valid three cycles after a lone request");
    collect_and_check();
    repeat (N_EXACT) send_random(1'b0);
    collect_and_check();
  endtask

  task automatic test_approx();
    logic [7:0] data;
    write_cfg(CFG_MODE, 8'd1);
    read_cfg(CFG_MODE, data);
    check_eq(data, 8'd1, "mode after write");
    repeat (N_APPROX) send_random(1'b1);
    collect_and_check();
    write_cfg(CFG_MODE, 8'd0);
  endtask

  task automatic test_div_by_zero();
    logic [7:0] data;
    repeat (N_DBZ) begin
      rng = xorshift32(rng);
      send_req(rng[15:0], 8'd0, 1'b0);
    end
    collect_and_check();
    read_cfg(CFG_DBZ_COUNT, data);
    check_eq(data, 8'(N_DBZ), "divide-by-zero count");
    write_cfg(CFG_DBZ_COUNT, 8'd0);
    read_cfg(CFG_DBZ_COUNT, data);
    check_eq(data, 8'd0, "divide-by-zero count after clear");
  endtask

  task automatic test_back_pressure();
    int seen;
    int waited;
    repeat (4) next_cycle(); // Let the last credit go home.
    hold_rsp = 1'b1;
    repeat (N_BP) send_random(1'b0);
    repeat (20) next_cycle();
    check_eq(got_q.size(), RSP_CREDITS, "results delivered without credits");
    check_eq(sent_count - credit_count, FIFO_DEPTH, "upstream credits outstanding");
    seen = credit_count;
    repeat (10) next_cycle();
    check_eq(credit_count, seen, "req_credit pulses while the buffer is full");
    hold_rsp = 1'b0;
    collect_and_check();
    waited = 0;
    while (credit_count != sent_count && waited < WAIT_LIMIT) begin
      next_cycle();
      waited++;
    end
    if (credit_count != sent_count) begin
      other_errors++;
      $display("Upstream credits never all came back, %0d missing", sent_count - credit_count);
    end
  endtask

  // Results and upstream credits are sampled mid-cycle.
  always @(negedge clk) begin
    if (!reset) begin
      if (rsp_valid) begin
        got_q.push_back(rsp);
        owed++;
      end
      if (req_credit) credit_count++;
    end
  end

  // Downstream credit return, one per cycle.
  always @(posedge clk) begin
    give_credit = !reset && !hold_rsp && owed > 0;
    #2;
    rsp_credit = give_credit;
    if (give_credit) owed--;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired before the tests completed");
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    reset      = 1'b1;
    req_valid  = 1'b0;
    req        = '0;
    rsp_credit = 1'b0;
    cfg_we     = 1'b0;
    cfg_addr   = CFG_MODE;
    cfg_wdata  = 8'd0;
    repeat (16) @(posedge clk);
    #2;
    reset = 1'b0;
    test_reset_state();
    test_exact();
    test_approx();
    test_div_by_zero();
    test_back_pressure();
    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
hw/div_types_pkg.sv
hw/div_cfg_pkg.sv
hw/divider_array.sv
hw/div_req_fifo.sv
hw/div_mode_regs.sv
hw/div_issue_ctrl.sv
hw/approx_div_unit.sv
tb/tb_clock_gen.sv
tb/approx_div_tb.sv

// File: Bender.yml
package:
  name: approx_div_unit

sources:
  - hw/div_types_pkg.sv
  - hw/div_cfg_pkg.sv
  - hw/divider_array.sv
  - hw/div_req_fifo.sv
  - hw/div_mode_regs.sv
  - hw/div_issue_ctrl.sv
  - hw/approx_div_unit.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/approx_div_tb.sv
